// ==== rv32_pkg.sv ====
package rv32_pkg;

    // datapath width of the core
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;

    // alu operation select, arithmetic first and then branch compares
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9,
        BEQ  = 4'd10,
        BNE  = 4'd11,
        BLT  = 4'd12,
        BGE  = 4'd13,
        BLTU = 4'd14,
        BGEU = 4'd15
    } operation_t;

    // major opcodes handled by the execute stage
    localparam logic [6:0] opc_op     = 7'b0110011;   // r-type arithmetic
    localparam logic [6:0] opc_op_imm = 7'b0010011;   // i-type arithmetic
    localparam logic [6:0] opc_branch = 7'b1100011;   // conditional branch

    // funct7 encodings
    // alt selects sub and sra, everything else wants base
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

endpackage

// ==== alu_control_unit.sv ====
`timescale 1ns/1ps

module alu_control_unit (
    input  logic [6:0]             opcode,
    input  logic [2:0]             alu_op,             // funct3 field
    input  logic [6:0]             func7,
    output rv32_pkg::operation_t   alu_control_input,
    output logic                   ctrl_err
);

    import rv32_pkg::*;

    always_comb
    begin
        alu_control_input = ADD;
        ctrl_err          = 1'b0;

        case (opcode)
            opc_op:
            begin
                case (alu_op)
                    3'b000: alu_control_input = (func7 == f7_alt) ? SUB : ADD;
                    3'b001: alu_control_input = SLL;
                    3'b010: alu_control_input = SLT;
                    3'b011: alu_control_input = SLTU;
                    3'b100: alu_control_input = XOR;
                    3'b101: alu_control_input = (func7 == f7_alt) ? SRA : SRL;
                    3'b110: alu_control_input = OR;
                    default: alu_control_input = AND;
                endcase
                // only add/sub and srl/sra accept the alternate funct7
                if (!((func7 == f7_base) ||
                      ((func7 == f7_alt) && ((alu_op == 3'b000) || (alu_op == 3'b101)))))
                    ctrl_err = 1'b1;
            end

            opc_op_imm:
            begin
                // funct7 is part of the immediate here, except on shifts
                case (alu_op)
                    3'b000: alu_control_input = ADD;
                    3'b001:
                    begin
                        alu_control_input = SLL;
                        ctrl_err          = (func7 != f7_base);
                    end
                    3'b010: alu_control_input = SLT;
                    3'b011: alu_control_input = SLTU;
                    3'b100: alu_control_input = XOR;
                    3'b101:
                    begin
                        alu_control_input = (func7 == f7_alt) ? SRA : SRL;
                        ctrl_err          = (func7 != f7_base) && (func7 != f7_alt);
                    end
                    3'b110: alu_control_input = OR;
                    default: alu_control_input = AND;
                endcase
            end

            opc_branch:
            begin
                case (alu_op)
                    3'b000: alu_control_input = BEQ;
                    3'b001: alu_control_input = BNE;
                    3'b100: alu_control_input = BLT;
                    3'b101: alu_control_input = BGE;
                    3'b110: alu_control_input = BLTU;
                    3'b111: alu_control_input = BGEU;
                    default: ctrl_err = 1'b1;       // funct3 2 and 3 are reserved
                endcase
            end

            default: ctrl_err = 1'b1;              // loads, stores, jumps etc not here
        endcase

        if (ctrl_err)
            alu_control_input = ADD;
    end

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [6:0]      opcode,
    input  logic [2:0]      alu_op,
    input  logic [6:0]      func7,
    input  rv32_pkg::word_t opA,
    input  rv32_pkg::word_t opB,
    output rv32_pkg::word_t alu_result,
    output logic            zero_flag,
    output logic            err_flag,
    output logic            cond_jump_value
);

    import rv32_pkg::*;

    logic signed [xlen-1:0] opa_signed;
    logic signed [xlen-1:0] opb_signed;
    operation_t             alu_control_input;
    logic                   ctrl_err;
    logic [4:0]             shamt;

    assign opa_signed = opA;
    assign opb_signed = opB;
    assign shamt      = opB[4:0];   // only the low five bits count for shifts

    alu_control_unit u_ctrl (
        .opcode            (opcode),
        .alu_op            (alu_op),
        .func7             (func7),
        .alu_control_input (alu_control_input),
        .ctrl_err          (ctrl_err)
    );

    always_comb
    begin
        alu_result      = '0;   // branches leave the result at zero
        cond_jump_value = 1'b0;

        case (alu_control_input)
            ADD:  alu_result = opA + opB;      // carry out is dropped
            SUB:  alu_result = opA - opB;
            SLL:  alu_result = opA << shamt;
            SLT:  alu_result = (opa_signed < opb_signed) ? word_t'(1) : '0;
            SLTU: alu_result = (opA < opB) ? word_t'(1) : '0;
            XOR:  alu_result = opA ^ opB;
            SRL:  alu_result = opA >> shamt;
            SRA:  alu_result = opa_signed >>> shamt;
            OR:   alu_result = opA | opB;
            AND:  alu_result = opA & opB;

            // branch compares
            BEQ:  cond_jump_value = (opA == opB);
            BNE:  cond_jump_value = (opA != opB);
            BLT:  cond_jump_value = (opa_signed < opb_signed);
            BGE:  cond_jump_value = (opa_signed >= opb_signed);
            BLTU: cond_jump_value = (opA < opB);
            BGEU: cond_jump_value = (opA >= opB);
        endcase

        // control unit falls back to ADD on a bad encoding, so squash it here
        if (ctrl_err)
        begin
            alu_result      = '0;
            cond_jump_value = 1'b0;
        end
    end

    assign err_flag  = ctrl_err;
    assign zero_flag = (alu_result == '0);

endmodule

// ==== imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
    input  rv32_pkg::word_t instr,
    output rv32_pkg::word_t imm
);

    import rv32_pkg::*;

    logic [6:0] opcode;
    word_t      imm_i;
    word_t      imm_b;

    assign opcode = instr[6:0];

    // i-type, 12 bits from the top of the word
    assign imm_i = {{20{instr[31]}}, instr[31:20]};

    // b-type, scattered fields and bit 0 always zero
    assign imm_b = {{19{instr[31]}},
                    instr[31],
                    instr[7],
                    instr[30:25],
                    instr[11:8],
                    1'b0};

    always_comb
    begin
        case (opcode)
            opc_op_imm: imm = imm_i;
            opc_branch: imm = imm_b;
            default:    imm = '0;       // r-type and unsupported opcodes
        endcase
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
    parameter int num_regs = 32     // 16 for rv32e
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    output rv32_pkg::word_t rs1_data,
    output rv32_pkg::word_t rs2_data,
    input  logic            we,
    input  logic [4:0]      waddr,
    input  rv32_pkg::word_t wdata
);

    import rv32_pkg::*;

    word_t regs [num_regs];

    // x0 and anything past the last implemented register read as zero
    function automatic word_t read_port(input logic [4:0] addr);
        word_t value;
        value = '0;
        if ((addr != 5'd0) && (int'(addr) < num_regs))
            value = regs[addr];
        return value;
    endfunction

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end
        else if (we && (waddr != 5'd0) && (int'(waddr) < num_regs))
        begin
            regs[waddr] <= wdata;   // seen by the next instruction, no bypass needed
        end
    end

endmodule

// ==== exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage #(
    parameter int num_regs = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid,
    input  rv32_pkg::word_t instr,
    input  rv32_pkg::word_t pc,
    output logic            result_valid,
    output logic [4:0]      rd_addr,
    output rv32_pkg::word_t rd_data,
    output logic            result_zero,
    output logic            branch_taken,
    output rv32_pkg::word_t branch_target,
    output logic            err
);

    import rv32_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;

    word_t      imm;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      opA;
    word_t      opB;
    word_t      alu_result;
    word_t      target;
    logic       zero_flag;
    logic       err_flag;
    logic       cond_jump_value;

    logic       is_arith;
    logic       is_branch;
    logic       wb_en;

    // instruction fields
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign is_arith  = (opcode == opc_op) || (opcode == opc_op_imm);
    assign is_branch = (opcode == opc_branch);

    imm_gen u_imm (
        .instr (instr),
        .imm   (imm)
    );

    reg_file #(
        .num_regs (num_regs)
    ) u_regs (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (wb_en),
        .waddr    (rd),
        .wdata    (alu_result)
    );

    // immediate replaces rs2 only for op-imm
    assign opA = rs1_data;
    assign opB = (opcode == opc_op_imm) ? imm : rs2_data;

    alu u_alu (
        .opcode          (opcode),
        .alu_op          (funct3),
        .func7           (funct7),
        .opA             (opA),
        .opB             (opB),
        .alu_result      (alu_result),
        .zero_flag       (zero_flag),
        .err_flag        (err_flag),
        .cond_jump_value (cond_jump_value)
    );

    assign target = pc + imm;   // imm holds the b-type offset on branches

    // write back arithmetic results, never a bad encoding, never x0
    assign wb_en = instr_valid && is_arith && !err_flag && (rd != 5'd0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            result_valid <= 1'b0;
            branch_taken <= 1'b0;
            err          <= 1'b0;
        end
        else
        begin
            result_valid <= instr_valid;    // one pulse per accepted instruction
            if (instr_valid)
            begin
                branch_taken <= is_branch && cond_jump_value;
                err          <= err_flag;
            end
        end
    end

    // payload, overwritten on every valid cycle
    always_ff @(posedge clk)
    begin
        if (instr_valid)
        begin
            rd_addr       <= rd;
            rd_data       <= alu_result;
            result_zero   <= zero_flag;
            branch_target <= target;
        end
    end

endmodule

// ==== exec_stage_tb_tasks.svh ====
`ifndef exec_stage_tb_tasks_svh
`define exec_stage_tb_tasks_svh

word_t shadow [32];     // expected register contents, x0 stays zero

function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                 input logic [4:0] rd, input logic [4:0] rs1,
                                 input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, op_r};
endfunction

function automatic word_t i_type(input logic [2:0] f3, input logic [4:0] rd,
                                 input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op_i};
endfunction

// offset is the signed byte distance, bit 0 is dropped by the format
function automatic word_t b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                 input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_b};
endfunction

// expected result of one instruction from the rv32i rules and the shadow registers
task automatic predict(input word_t ins, output word_t data, output logic taken,
                       output logic bad);
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    logic       alt;
    word_t      a;
    word_t      b;
    opc = ins[6:0];
    f7 = ins[31:25];
    f3 = ins[14:12];
    alt = (f7 == 7'h20);
    a = shadow[ins[19:15]];
    b = (opc == op_i) ? {{20{ins[31]}}, ins[31:20]} : shadow[ins[24:20]];
    data = '0;
    taken = 1'b0;
    if (opc == op_r)
        bad = !((f7 == 7'h00) || (alt && ((f3 == 3'd0) || (f3 == 3'd5))));
    else if (opc == op_i)
        bad = ((f3 == 3'd1) && (f7 != 7'h00)) || ((f3 == 3'd5) && (f7 != 7'h00) && !alt);
    else if (opc == op_b)
        bad = (f3 == 3'd2) || (f3 == 3'd3);
    else
        bad = 1'b1;
    if (!bad && (opc == op_b))
    begin
        case (f3)
            3'd0: taken = (a == b);
            3'd1: taken = (a != b);
            3'd4: taken = ($signed(a) < $signed(b));
            3'd5: taken = ($signed(a) >= $signed(b));
            3'd6: taken = (a < b);
            default: taken = (a >= b);
        endcase
    end
    else if (!bad)
    begin
        case (f3)
            3'd0: data = ((opc == op_r) && alt) ? a - b : a + b;
            3'd1: data = a << b[4:0];
            3'd2: data = {31'b0, $signed(a) < $signed(b)};
            3'd3: data = {31'b0, a < b};
            3'd4: data = a ^ b;
            3'd5:
            begin
                if (alt)
                    data = $signed(a) >>> b[4:0];
                else
                    data = a >> b[4:0];
            end
            3'd6: data = a | b;
            default: data = a & b;
        endcase
    end
endtask

task automatic check_word(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected)
    begin
        errors++;
        $display("[ERROR] %s expected 0x%08h got 0x%08h at %0t", name, expected, actual, $time);
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected)
    begin
        errors++;
        $display("[ERROR] %s expected 0x%1h got 0x%1h at %0t", name, expected, actual, $time);
    end
endtask

task automatic check_addr(input string name, input logic [4:0] expected,
                          input logic [4:0] actual);
    checks++;
    if (actual !== expected)
    begin
        errors++;
        $display("[ERROR] %s expected 0x%02h got 0x%02h at %0t", name, expected, actual, $time);
    end
endtask

// drive one instruction and check the registered outputs one edge later
task automatic issue_at(input word_t ins, input word_t pc_v, input word_t exp_target);
    word_t data;
    logic  taken;
    logic  bad;
    predict(ins, data, taken, bad);
    instr = ins;
    pc = pc_v;
    instr_valid = 1'b1;
    @(posedge clk);
    #0.5;
    instr_valid = 1'b0;     // the next issue raises it again in the same step
    check_bit("result_valid", 1'b1, result_valid);
    check_addr("rd_addr", ins[11:7], rd_addr);
    check_word("rd_data", data, rd_data);
    check_bit("result_zero", data == '0, result_zero);
    check_bit("branch_taken", taken, branch_taken);
    check_bit("err", bad, err);
    if ((ins[6:0] == op_b) && !bad)
        check_word("branch_target", exp_target, branch_target);
    if (!bad && (ins[6:0] != op_b) && (ins[11:7] != 5'd0))
        shadow[ins[11:7]] = data;
endtask

task automatic issue(input word_t ins);
    issue_at(ins, 32'h0000_0100, 32'h0);
endtask

`endif

// ==== exec_stage_tb.sv ====
`timescale 1ns/1ps

module exec_stage_tb;

    import rv32_pkg::*;

    localparam int          reset_cycles   = 8;
    localparam int          est_instrs     = 250;
    localparam int          timeout_cycles = 12 * est_instrs;  // plenty of slack per instr
    localparam logic [31:0] seed           = 32'h09b12597;
    localparam logic [6:0]  op_r           = 7'b0110011;
    localparam logic [6:0]  op_i           = 7'b0010011;
    localparam logic [6:0]  op_b           = 7'b1100011;

    logic       clk = 1'b0;
    logic       rst;
    logic       instr_valid;
    word_t      instr;
    word_t      pc;
    logic       result_valid;
    logic [4:0] rd_addr;
    word_t      rd_data;
    logic       result_zero;
    logic       branch_taken;
    word_t      branch_target;
    logic       err;
    int         checks = 0;
    int         errors = 0;
    int         cycles = 0;

    always #2 clk = ~clk;

    exec_stage #(.num_regs(32)) DUT (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .pc            (pc),
        .result_valid  (result_valid),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .result_zero   (result_zero),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .err           (err)
    );

    `include "exec_stage_tb_tasks.svh"

    function automatic logic [4:0] rand_reg();
        return 5'(1 + $urandom % 31);   // never x0
    endfunction

    // builds any 32-bit value from addi, slli and ori
    task automatic load_word(input logic [4:0] rd, input word_t value);
        issue(i_type(3'd0, rd, 5'd0, {1'b0, value[31:21]}));
        issue(i_type(3'd1, rd, rd, 12'd11));
        issue(i_type(3'd6, rd, rd, {1'b0, value[20:10]}));
        issue(i_type(3'd1, rd, rd, 12'd10));
        issue(i_type(3'd6, rd, rd, {2'b0, value[9:0]}));
    endtask

    task automatic reset_state_check();
        check_bit("result_valid", 1'b0, result_valid);
        check_bit("err", 1'b0, err);
        check_bit("branch_taken", 1'b0, branch_taken);
        issue(r_type(7'h00, 3'd0, 5'd5, 5'd0, 5'd0));  // add x5, x0, x0
        issue(r_type(7'h00, 3'd6, 5'd6, 5'd31, 5'd17));
    endtask

    task automatic immediate_ops();
        logic [2:0]  f3;
        logic [11:0] imm;
        issue(i_type(3'd0, 5'd1, 5'd0, 12'd1234));
        issue(i_type(3'd0, 5'd2, 5'd0, 12'h400));       // upper bits look like the sub funct7
        issue(i_type(3'd0, 5'd3, 5'd2, 12'hfff));
        repeat (12)
            issue(i_type(3'd0, rand_reg(), 5'd0, 12'($urandom)));
        repeat (40)
        begin
            f3 = 3'($urandom);
            imm = 12'($urandom);
            if (f3 == 3'd1)
                imm[11:5] = 7'h00;
            else if (f3 == 3'd5)
                imm[11:5] = {1'b0, imm[10], 5'b0};      // srli or srai
            issue(i_type(f3, rand_reg(), rand_reg(), imm));
        end
        issue(i_type(3'd0, 5'd0, 5'd1, 12'd77));        // x0 write must be dropped
        issue(i_type(3'd0, 5'd7, 5'd0, 12'd0));
    endtask

    task automatic register_ops();
        logic [2:0] f3;
        logic [6:0] f7;
        logic [4:0] rd;
        logic [4:0] prev;
        load_word(5'd1, 32'h8000_0000);
        load_word(5'd2, 32'h7fff_ffff);
        load_word(5'd3, 32'hffff_ffff);
        load_word(5'd4, 32'h0000_0021);                 // shift amount above 31
        for (int op = 0; op < 10; op++)
        begin
            f3 = (op == 9) ? 3'd5 : 3'(op % 8);
            f7 = (op >= 8) ? 7'h20 : 7'h00;
            for (int p = 0; p < 4; p++)
                issue(r_type(f7, f3, 5'(5 + p), 5'(1 + p), 5'(1 + (p + 1) % 4)));
        end
        load_word(5'd9, $urandom);
        load_word(5'd10, $urandom);
        load_word(5'd11, $urandom);
        prev = 5'd9;
        repeat (40)
        begin
            f3 = 3'($urandom);
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2 == 1) ? 7'h20 : 7'h00;
            rd = rand_reg();
            issue(r_type(f7, f3, rd, prev, rand_reg()));    // chained on the last result
            prev = rd;
        end
    endtask

    task automatic branch_ops();
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [12:0] off;
        word_t       pc_v;
        load_word(5'd10, 32'h8000_0000);
        load_word(5'd11, 32'h0000_0005);
        load_word(5'd12, 32'h0000_0005);
        load_word(5'd13, $urandom);
        for (int f = 0; f < 8; f++)
        begin
            if (f == 2 || f == 3)
                continue;
            for (int p = 0; p < 4; p++)
            begin
                // equal, signed less but unsigned greater, the reverse, random
                rs1 = (p == 1) ? 5'd10 : (p == 3) ? 5'd13 : 5'd11;
                rs2 = (p == 0) ? 5'd12 : (p == 2) ? 5'd10 : (p == 1) ? 5'd11 : 5'd12;
                off = 13'($urandom);
                off[0] = 1'b0;
                off[12] = p[0];
                pc_v = $urandom & 32'hffff_fffc;
                issue_at(b_type(3'(f), rs1, rs2, off), pc_v, pc_v + {{19{off[12]}}, off});
            end
        end
    endtask

    task automatic error_cases();
        load_word(5'd5, 32'h1234_5678);
        issue({12'h0, 5'd1, 3'd2, 5'd5, 7'b0000011});   // load opcode
        issue(i_type(3'd0, 5'd6, 5'd5, 12'd0));
        issue(r_type(7'h01, 3'd0, 5'd5, 5'd1, 5'd2));   // mul encoding
        issue(i_type(3'd0, 5'd6, 5'd5, 12'd0));
        issue(b_type(3'd2, 5'd1, 5'd2, 13'd8));
        issue(i_type(3'd1, 5'd5, 5'd5, 12'h401));       // slli with funct7 bits set
        issue(i_type(3'd0, 5'd6, 5'd5, 12'd0));
        check_word("x5 readback", 32'h1234_5678, rd_data);
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= timeout_cycles)
        begin
            $display("timeout after %0d cycles, %0d errors so far", cycles, errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(seed));
        foreach (shadow[i])
            shadow[i] = '0;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        repeat (reset_cycles) @(posedge clk);
        #0.5;
        rst = 1'b0;
        reset_state_check();
        immediate_ops();
        register_ops();
        branch_ops();
        error_cases();
        @(posedge clk);
        #0.5;
        check_bit("result_valid", 1'b0, result_valid);  // nothing left in flight
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
rv32_pkg.sv
alu_control_unit.sv
alu.sv
imm_gen.sv
reg_file.sv
exec_stage.sv
exec_stage_tb.sv

// ==== Makefile ====
# Verilator build and run for the execute stage testbench

VERILATOR  ?= verilator
FILE_LIST  ?= list.f
TB_TOP     ?= exec_stage_tb
RTL_TOP    ?= exec_stage
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

# the run fails unless the pass line shows up in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
